// ==== hw/mm_bridge_pkg.sv ====
// Shared timing constants, width types and command structs for the slave bridge.
// Imported by every RTL block and by the testbench.

package mm_bridge_pkg;

   // -------------------------------------------------------------------------
   // Slave timing, in clock cycles
   // -------------------------------------------------------------------------
   localparam int unsigned SETUP_CYCLES      = 1;
   localparam int unsigned READ_WAIT_CYCLES  = 2;
   localparam int unsigned WRITE_WAIT_CYCLES = 0;
   localparam int unsigned DATA_HOLD_CYCLES  = 1;

   // Cycles from read acceptance to valid data
   localparam int unsigned READ_LATENCY = 2;

   // Word geometry
   localparam int unsigned BYTES_PER_WORD = 4;
   localparam int unsigned WORD_SHIFT     = 2;

   // -------------------------------------------------------------------------
   // Width types
   // -------------------------------------------------------------------------
   typedef logic [31:0] uav_addr_t;
   typedef logic [29:0] av_addr_t;
   typedef logic [5:0]  uav_burst_t;
   typedef logic [3:0]  av_burst_t;
   typedef logic [31:0] data_t;
   typedef logic [3:0]  byte_en_t;
   typedef logic [1:0]  wait_count_t;

   // Counter values derived from the slave timing
   localparam wait_count_t READ_DONE_COUNT  = wait_count_t'(SETUP_CYCLES + READ_WAIT_CYCLES);
   localparam wait_count_t WRITE_END_COUNT  = wait_count_t'(SETUP_CYCLES + WRITE_WAIT_CYCLES);
   localparam wait_count_t WRITE_DONE_COUNT = wait_count_t'(WRITE_END_COUNT + DATA_HOLD_CYCLES);

   // -------------------------------------------------------------------------
   // Command structs
   // -------------------------------------------------------------------------
   // Upstream byte-addressed command
   typedef struct packed {
      uav_addr_t  address;
      data_t      writedata;
      byte_en_t   byteenable;
      uav_burst_t burstcount;
      logic       read;
      logic       write;
      logic       lock;
      logic       debugaccess;
   } uav_cmd_t;

   // Downstream word-addressed slave signals
   typedef struct packed {
      av_addr_t  address;
      data_t     writedata;
      byte_en_t  byteenable;
      byte_en_t  writebyteenable;
      av_burst_t burstcount;
      logic      read;
      logic      write;
      logic      begintransfer;
      logic      beginbursttransfer;
      logic      chipselect;
      logic      outputenable;
      logic      lock;
      logic      debugaccess;
   } av_cmd_t;

endpackage

// ==== hw/wait_state_gen.sv ====
// Wait-state counter for a slave without its own waitrequest.
// Makes upstream waitrequest, the read-accept pulse and the timed av strobes.

`timescale 1ns/10ps

module wait_state_gen (
   input  logic clk,
   input  logic reset,
   input  logic read,
   input  logic write,
   output logic waitrequest,
   output logic read_accept,
   output logic av_read,
   output logic av_write
);
   import mm_bridge_pkg::*;

   wait_count_t count;
   logic        override_q;
   logic        past_setup;
   logic        in_write_window;
   logic        wait_read;
   logic        wait_write;

   // -------------------------------------------------------------------------
   // Cycle counter
   // -------------------------------------------------------------------------
   // Holds waitrequest high in the first cycle out of reset
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         override_q <= 1'b1;
      end else begin
         override_q <= 1'b0;
      end
   end

   // Counts the cycles of the held command and clears on acceptance
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         count <= '0;
      end else begin
         if (!waitrequest || override_q) begin
            count <= '0;
         end else if (read || write) begin
            count <= count + wait_count_t'(1);
         end else begin
            count <= '0;
         end
      end
   end

   // -------------------------------------------------------------------------
   // Strobe windows
   // -------------------------------------------------------------------------
   assign past_setup      = count >= wait_count_t'(SETUP_CYCLES);
   assign in_write_window = count <= WRITE_END_COUNT;

   // Read stays up to acceptance while write drops for the hold phase
   assign av_read  = read & past_setup;
   assign av_write = write & past_setup & in_write_window;

   // Done counts per direction
   assign wait_read  = count != READ_DONE_COUNT;
   assign wait_write = count != WRITE_DONE_COUNT;

   always_comb begin
      if (write) begin
         waitrequest = wait_write | override_q;
      end else begin
         waitrequest = wait_read | override_q;
      end
   end

   // Starts the read latency pipe
   assign read_accept = read & ~waitrequest;

endmodule

// ==== hw/read_latency_track.sv ====
// Fixed read latency tracking. Makes upstream readdatavalid and keeps
// chipselect and outputenable asserted until the read data has returned.

`timescale 1ns/10ps

module read_latency_track (
   input  logic clk,
   input  logic reset,
   input  logic read,
   input  logic write,
   input  logic read_accept,
   output logic readdatavalid,
   output logic chipselect,
   output logic outputenable
);
   import mm_bridge_pkg::*;

   logic [READ_LATENCY-1:0] latency_q;
   logic                    in_flight;
   logic                    read_hold_q;

   // -------------------------------------------------------------------------
   // Latency pipe
   // -------------------------------------------------------------------------
   // One bit per accepted read, overlapping reads allowed
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         latency_q <= '0;
      end else begin
         latency_q <= {latency_q[READ_LATENCY-2:0], read_accept};
      end
   end

   // Last stage lines up with slave data
   assign readdatavalid = latency_q[READ_LATENCY-1];

   // -------------------------------------------------------------------------
   // Chipselect and outputenable extension
   // -------------------------------------------------------------------------
   // Reads that still need another cycle before their data
   assign in_flight = |latency_q[READ_LATENCY-2:0];

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         read_hold_q <= 1'b0;
      end else begin
         read_hold_q <= read | in_flight;
      end
   end

   // Writes only hold chipselect while the command is up
   assign chipselect   = read | write | read_hold_q;
   assign outputenable = read | read_hold_q;

endmodule

// ==== hw/transfer_framer.sv ====
// Begintransfer and beginbursttransfer framing plus byte to word conversion.
// Address and burst count are held from the first beat for a write burst.

`timescale 1ns/10ps

module transfer_framer (
   input  logic                      clk,
   input  logic                      reset,
   input  mm_bridge_pkg::uav_cmd_t   cmd,
   input  logic                      waitrequest,
   output logic                      begintransfer,
   output logic                      beginbursttransfer,
   output mm_bridge_pkg::av_addr_t   address,
   output mm_bridge_pkg::av_burst_t  burstcount
);
   import mm_bridge_pkg::*;

   logic      active;
   logic      last_beat;
   logic      end_begin_q;
   logic      in_burst_q;
   av_addr_t  word_address;
   av_burst_t word_count;
   av_addr_t  address_q;
   av_burst_t burst_q;

   assign active    = cmd.read | cmd.write;
   assign last_beat = cmd.burstcount == uav_burst_t'(BYTES_PER_WORD);

   // -------------------------------------------------------------------------
   // Begintransfer
   // -------------------------------------------------------------------------
   // High in the first cycle of a command only
   assign begintransfer = active & ~end_begin_q;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         end_begin_q <= 1'b0;
      end else begin
         if (begintransfer && waitrequest) begin
            end_begin_q <= 1'b1;
         end else if (!waitrequest) begin
            end_begin_q <= 1'b0;
         end
      end
   end

   // -------------------------------------------------------------------------
   // Beginbursttransfer
   // -------------------------------------------------------------------------
   // Every read starts its own burst
   // A write burst starts when no burst is open
   always_comb begin
      if (cmd.read) begin
         beginbursttransfer = begintransfer;
      end else begin
         beginbursttransfer = begintransfer & ~in_burst_q;
      end
   end

   // Burst stays open until a beat with one word left
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         in_burst_q <= 1'b0;
      end else begin
         if (cmd.write && last_beat) begin
            in_burst_q <= 1'b0;
         end else if (cmd.write) begin
            in_burst_q <= 1'b1;
         end
      end
   end

   // -------------------------------------------------------------------------
   // Word address and count
   // -------------------------------------------------------------------------
   assign word_address = cmd.address[$bits(uav_addr_t)-1:WORD_SHIFT];
   assign word_count   = cmd.burstcount[$bits(uav_burst_t)-1:WORD_SHIFT];

   always_ff @(posedge clk) begin
      if (beginbursttransfer) begin
         address_q <= word_address;
         burst_q   <= word_count;
      end
   end

   // Later beats show the values of the first one
   assign address    = beginbursttransfer ? word_address : address_q;
   assign burstcount = beginbursttransfer ? word_count : burst_q;

endmodule

// ==== hw/mm_slave_bridge.sv ====
// Top level of the slave bridge from a byte-addressed master to a fixed-timing
// word-addressed slave. Joins the wait-state, framing and read-latency blocks.

`timescale 1ns/10ps

module mm_slave_bridge (
   input  logic                    clk,
   input  logic                    reset,
   input  mm_bridge_pkg::uav_cmd_t uav_cmd,
   output logic                    uav_waitrequest,
   output mm_bridge_pkg::data_t    uav_readdata,
   output logic                    uav_readdatavalid,
   output mm_bridge_pkg::av_cmd_t  av_cmd,
   input  mm_bridge_pkg::data_t    av_readdata
);
   import mm_bridge_pkg::*;

   logic      read_accept;
   logic      av_read;
   logic      av_write;
   logic      begintransfer;
   logic      beginbursttransfer;
   av_addr_t  word_address;
   av_burst_t word_count;
   logic      chipselect;
   logic      outputenable;

   // -------------------------------------------------------------------------
   // Wait states and timed strobes
   // -------------------------------------------------------------------------
   wait_state_gen i_wait_state_gen (
      .clk         (clk),
      .reset       (reset),
      .read        (uav_cmd.read),
      .write       (uav_cmd.write),
      .waitrequest (uav_waitrequest),
      .read_accept (read_accept),
      .av_read     (av_read),
      .av_write    (av_write)
   );

   // Transfer framing and address conversion
   transfer_framer i_transfer_framer (
      .clk                (clk),
      .reset              (reset),
      .cmd                (uav_cmd),
      .waitrequest        (uav_waitrequest),
      .begintransfer      (begintransfer),
      .beginbursttransfer (beginbursttransfer),
      .address            (word_address),
      .burstcount         (word_count)
   );

   // Readdatavalid plus chipselect and outputenable extension
   read_latency_track i_read_latency_track (
      .clk           (clk),
      .reset         (reset),
      .read          (uav_cmd.read),
      .write         (uav_cmd.write),
      .read_accept   (read_accept),
      .readdatavalid (uav_readdatavalid),
      .chipselect    (chipselect),
      .outputenable  (outputenable)
   );

   // -------------------------------------------------------------------------
   // Downstream command assembly
   // -------------------------------------------------------------------------
   always_comb begin
      av_cmd.address            = word_address;
      av_cmd.burstcount         = word_count;
      av_cmd.read               = av_read;
      av_cmd.write              = av_write;
      av_cmd.begintransfer      = begintransfer;
      av_cmd.beginbursttransfer = beginbursttransfer;
      av_cmd.chipselect         = chipselect;
      av_cmd.outputenable       = outputenable;

      // Straight pass-through fields
      av_cmd.writedata   = uav_cmd.writedata;
      av_cmd.byteenable  = uav_cmd.byteenable;
      av_cmd.lock        = uav_cmd.lock;
      av_cmd.debugaccess = uav_cmd.debugaccess;

      // Byte lanes only qualified on writes
      av_cmd.writebyteenable = uav_cmd.byteenable & {$bits(byte_en_t){uav_cmd.write}};
   end

   // Slave data goes up unchanged, qualified by readdatavalid
   assign uav_readdata = av_readdata;

endmodule

// ==== dv/bridge_ref.svh ====
// Reference model of the bridge for the testbench: word conversion, slave read
// data and the command cycle timing. Included inside the testbench module.

`ifndef BRIDGE_REF_SVH
`define BRIDGE_REF_SVH

// Run lengths
localparam int CLK_PERIOD_NS      = 4;
localparam int RESET_CYCLES       = 3;
localparam int CMD_TIMEOUT_CYCLES = 8;
localparam int RANDOM_OPS         = 40;
localparam int DIRECTED_CYCLES    = 100;
localparam int MAX_OP_CYCLES      = 16;
localparam int WATCHDOG_CYCLES    =
   2 * (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_OPS * MAX_OP_CYCLES);

// Command cycles, counted from 1 at the first cycle of a command
localparam int STROBE_FIRST_CYCLE      = SETUP_CYCLES + 1;
localparam int READ_ACCEPT_CYCLE       = SETUP_CYCLES + READ_WAIT_CYCLES + 1;
localparam int WRITE_STROBE_LAST_CYCLE = SETUP_CYCLES + WRITE_WAIT_CYCLES + 1;
localparam int WRITE_ACCEPT_CYCLE      = WRITE_STROBE_LAST_CYCLE + DATA_HOLD_CYCLES;

// Byte address to word address
function automatic av_addr_t word_addr(input uav_addr_t byte_addr);
   return av_addr_t'(byte_addr / BYTES_PER_WORD);
endfunction

// Byte count to word count
function automatic av_burst_t word_count(input uav_burst_t byte_count);
   return av_burst_t'(32'(byte_count) / BYTES_PER_WORD);
endfunction

// Slave memory contents, a fixed mix of the word address
function automatic data_t read_word(input av_addr_t addr);
   return {addr, 2'b01} ^ {addr[13:0], addr[29:12]} ^ 32'h5a3c_96e1;
endfunction

// Cycle in which the bridge takes the command
function automatic logic accept_cycle(input logic is_read, input int cycle);
   if (is_read) begin
      return cycle == READ_ACCEPT_CYCLE;
   end
   return cycle == WRITE_ACCEPT_CYCLE;
endfunction

`endif

// ==== dv/tb_mm_slave_bridge.sv ====
// Testbench for the slave bridge. Runs directed reads, writes and bursts, then a
// random mix, against a fixed-latency slave model and a cycle reference.

`timescale 1ns/10ps

module tb_mm_slave_bridge;
   import mm_bridge_pkg::*;
   `include "bridge_ref.svh"

   logic     clk;
   logic     reset;
   uav_cmd_t uav_cmd;
   logic     uav_waitrequest;
   data_t    uav_readdata;
   logic     uav_readdatavalid;
   av_cmd_t  av_cmd;
   data_t    av_readdata = '0;

   integer seed;
   int     errors = 0;
   int     timeouts = 0;
   int     checked_cycles = 0;
   int     tests_run = 0;
   int     tests_failed = 0;
   int     test_start_errors = 0;

   // Reference state of the compare process
   int         since_reset;
   int         cyc;
   logic       active;
   logic       accepted;
   logic       burst_open;
   uav_addr_t  burst_addr;
   uav_burst_t burst_cnt;
   av_addr_t   exp_addr;
   av_burst_t  exp_count;
   logic       exp_bt;
   logic       exp_rd;
   logic       exp_wr;
   logic       pv1;
   logic       pv2;
   data_t      pd1;
   data_t      pd2;

   // Slave model state
   av_addr_t take_addr = '0;
   av_addr_t pipe_addr = '0;

   mm_slave_bridge i_dut (
      .clk               (clk),
      .reset             (reset),
      .uav_cmd           (uav_cmd),
      .uav_waitrequest   (uav_waitrequest),
      .uav_readdata      (uav_readdata),
      .uav_readdatavalid (uav_readdatavalid),
      .av_cmd            (av_cmd),
      .av_readdata       (av_readdata)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD_NS / 2) clk = ~clk;
   end

   // ------------------------------------------------------------------------
   // Slave model, data READ_LATENCY cycles after the accepting cycle
   // ------------------------------------------------------------------------
   always @(negedge clk) begin
      if (av_cmd.read) begin
         take_addr = av_cmd.address;
      end
   end

   always @(posedge clk) begin
      pipe_addr   <= take_addr;
      av_readdata <= read_word(pipe_addr);
   end

   // ------------------------------------------------------------------------
   // Compare process, mid-cycle
   // ------------------------------------------------------------------------
   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
      errors++;
      $display("Mismatch %0s at %0t: got %h, expected %h", name, $time, got, expected);
   endtask

   always @(negedge clk) begin
      if (reset !== 1'b0) begin
         since_reset = 0;
         cyc = 0;
         burst_open = 1'b0;
         pv1 = 1'b0;
         pv2 = 1'b0;
      end else begin
         since_reset++;
         checked_cycles++;
         active = uav_cmd.read | uav_cmd.write;
         cyc = active ? cyc + 1 : 0;
         // First beat of a write burst fixes address and count
         if (active && cyc == 1 && uav_cmd.write && !burst_open) begin
            burst_addr = uav_cmd.address;
            burst_cnt  = uav_cmd.burstcount;
         end
         if (uav_cmd.write) begin
            exp_addr  = word_addr(burst_addr);
            exp_count = word_count(burst_cnt);
         end else begin
            exp_addr  = word_addr(uav_cmd.address);
            exp_count = word_count(uav_cmd.burstcount);
         end
         accepted = active && accept_cycle(uav_cmd.read, cyc);
         exp_bt = active && cyc == 1;
         exp_rd = uav_cmd.read && cyc >= STROBE_FIRST_CYCLE && cyc <= READ_ACCEPT_CYCLE;
         exp_wr = uav_cmd.write && cyc >= STROBE_FIRST_CYCLE && cyc <= WRITE_STROBE_LAST_CYCLE;

         if (since_reset == 1 && uav_waitrequest !== 1'b1)
            report_mismatch("uav_waitrequest", 32'(uav_waitrequest), 32'(1'b1));
         if (active && uav_waitrequest !== !accepted)
            report_mismatch("uav_waitrequest", 32'(uav_waitrequest), 32'(!accepted));
         if (av_cmd.read !== exp_rd)
            report_mismatch("av_cmd.read", 32'(av_cmd.read), 32'(exp_rd));
         if (av_cmd.write !== exp_wr)
            report_mismatch("av_cmd.write", 32'(av_cmd.write), 32'(exp_wr));
         if (av_cmd.begintransfer !== exp_bt)
            report_mismatch("av_cmd.begintransfer", 32'(av_cmd.begintransfer), 32'(exp_bt));
         if (av_cmd.beginbursttransfer !== (exp_bt && (uav_cmd.read || !burst_open)))
            report_mismatch("av_cmd.beginbursttransfer", 32'(av_cmd.beginbursttransfer),
                            32'(exp_bt && (uav_cmd.read || !burst_open)));
         if (av_cmd.chipselect !== (active | pv1 | pv2))
            report_mismatch("av_cmd.chipselect", 32'(av_cmd.chipselect), 32'(active | pv1 | pv2));
         if (av_cmd.outputenable !== (uav_cmd.read | pv1 | pv2))
            report_mismatch("av_cmd.outputenable", 32'(av_cmd.outputenable),
                            32'(uav_cmd.read | pv1 | pv2));
         if (av_cmd.writebyteenable !== (uav_cmd.write ? uav_cmd.byteenable : byte_en_t'(0)))
            report_mismatch("av_cmd.writebyteenable", 32'(av_cmd.writebyteenable),
                            32'(uav_cmd.write ? uav_cmd.byteenable : byte_en_t'(0)));
         if (av_cmd.byteenable !== uav_cmd.byteenable)
            report_mismatch("av_cmd.byteenable", 32'(av_cmd.byteenable), 32'(uav_cmd.byteenable));
         if ({av_cmd.lock, av_cmd.debugaccess} !== {uav_cmd.lock, uav_cmd.debugaccess})
            report_mismatch("av_cmd.lock/debugaccess", 32'({av_cmd.lock, av_cmd.debugaccess}),
                            32'({uav_cmd.lock, uav_cmd.debugaccess}));
         if (uav_cmd.write && av_cmd.writedata !== uav_cmd.writedata)
            report_mismatch("av_cmd.writedata", av_cmd.writedata, uav_cmd.writedata);
         if (active && av_cmd.address !== exp_addr)
            report_mismatch("av_cmd.address", 32'(av_cmd.address), 32'(exp_addr));
         if (active && av_cmd.burstcount !== exp_count)
            report_mismatch("av_cmd.burstcount", 32'(av_cmd.burstcount), 32'(exp_count));
         if (uav_readdatavalid !== pv2)
            report_mismatch("uav_readdatavalid", 32'(uav_readdatavalid), 32'(pv2));
         if (pv2 && uav_readdata !== pd2)
            report_mismatch("uav_readdata", uav_readdata, pd2);

         // Burst closes on the beat with one word left
         if (accepted && uav_cmd.write)
            burst_open = uav_cmd.burstcount != uav_burst_t'(BYTES_PER_WORD);
         if (accepted)
            cyc = 0;
         pv2 = pv1;
         pd2 = pd1;
         pv1 = accepted & uav_cmd.read;
         pd1 = read_word(word_addr(uav_cmd.address));
      end
   end

   // ------------------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------------------
   task automatic run_cmd(input logic is_write, input uav_addr_t addr, input data_t wdata,
                          input uav_burst_t count);
      uav_cmd_t c;
      int       waited;
      c.address     = addr;
      c.writedata   = wdata;
      c.byteenable  = byte_en_t'($random(seed));
      c.burstcount  = count;
      c.read        = !is_write;
      c.write       = is_write;
      c.lock        = 1'($random(seed));
      c.debugaccess = 1'($random(seed));
      @(posedge clk);
      uav_cmd <= c;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (uav_waitrequest && waited < CMD_TIMEOUT_CYCLES);
      if (uav_waitrequest) begin
         timeouts++;
         $display("Command at address %h was not accepted within %0d cycles", addr, waited);
      end
   endtask

   task automatic go_idle(input int cycles);
      @(posedge clk);
      uav_cmd <= '0;
      repeat (cycles - 1) @(posedge clk);
   endtask

   // Beats carry the bytes that remain
   task automatic write_burst(input uav_addr_t addr, input int beats);
      for (int i = 0; i < beats; i++) begin
         run_cmd(1'b1, addr + uav_addr_t'(i * BYTES_PER_WORD), $random(seed),
                 uav_burst_t'((beats - i) * BYTES_PER_WORD));
      end
   endtask

   task automatic finish_test(input string name);
      int failed;
      failed = errors + timeouts - test_start_errors;
      tests_run++;
      if (failed != 0) begin
         tests_failed++;
      end
      $display("test %-12s %0s, %0d errors", name, failed == 0 ? "ok" : "failed", failed);
      test_start_errors = errors + timeouts;
   endtask

   initial begin
      int        kind;
      uav_addr_t addr;
      seed = 32'h14ea900e;
      reset = 1'b1;
      uav_cmd = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      go_idle(6);
      finish_test("reset_idle");

      run_cmd(1'b0, 32'h0000_4a18, '0, uav_burst_t'(BYTES_PER_WORD));
      go_idle(4);
      finish_test("single_read");
      run_cmd(1'b1, 32'h0001_07c4, 32'hc0de_5a17, uav_burst_t'(BYTES_PER_WORD));
      go_idle(3);
      finish_test("single_write");
      write_burst(32'h0002_3300, 4);
      go_idle(3);
      finish_test("write_burst");

      // Read then write back to back, then two overlapping reads
      run_cmd(1'b0, 32'h0000_0ff0, '0, uav_burst_t'(BYTES_PER_WORD));
      run_cmd(1'b1, 32'h0000_0ff4, 32'h1234_abcd, uav_burst_t'(BYTES_PER_WORD));
      go_idle(2);
      run_cmd(1'b0, 32'h0003_1000, '0, uav_burst_t'(BYTES_PER_WORD));
      run_cmd(1'b0, 32'h0003_2004, '0, uav_burst_t'(BYTES_PER_WORD));
      go_idle(4);
      finish_test("cs_oe");

      for (int n = 0; n < RANDOM_OPS; n++) begin
         kind = int'($unsigned($random(seed)) % 3);
         addr = $random(seed);
         case (kind)
            0: run_cmd(1'b0, addr, '0, uav_burst_t'(BYTES_PER_WORD));
            1: run_cmd(1'b1, addr, $random(seed), uav_burst_t'(BYTES_PER_WORD));
            default: write_burst(addr, 2 + int'($unsigned($random(seed)) % 2));
         endcase
         if (($random(seed) & 32'h3) == 0) begin
            go_idle(2);
         end
      end
      go_idle(4);
      finish_test("random");

      $display("tests run %0d, tests failed %0d, cycles checked %0d, errors %0d",
               tests_run, tests_failed, checked_cycles, errors + timeouts);
      if (errors + timeouts == 0 && checked_cycles > 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   // Watchdog over the summed test lengths
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

// ==== mm_slave_bridge.f ====
+incdir+dv
hw/mm_bridge_pkg.sv
hw/wait_state_gen.sv
hw/read_latency_track.sv
hw/transfer_framer.sv
hw/mm_slave_bridge.sv
dv/tb_mm_slave_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the bridge testbench with Verilator and runs it once.
# Exits non-zero on a build error, a simulator error or a failing run.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f mm_slave_bridge.f --top-module tb_mm_slave_bridge
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/Vtb_mm_slave_bridge 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "STATUS: PASS"; then
   exit 0
fi
exit 1
